/* src/cart_pkg.sv */
package cart_pkg;

	// ==============================
	// Download stream
	// ==============================

	localparam logic [7:0] CART_INDEX  = 8'd0;
	localparam logic [7:0] CHEAT_INDEX = 8'd255;

	// Copier header in front of the ROM image
	localparam int HDR_SKIP    = 512;
	localparam int SECTOR_BITS = 9;

	typedef struct packed {
		logic        active;
		logic [7:0]  index;
		logic [24:0] addr;
		logic [15:0] data;
		logic        wr;
	} dl_word_t;

	// ==============================
	// Cartridge setup
	// ==============================

	typedef enum logic [2:0] {
		HDR_AUTO    = 3'd0,
		HDR_NONE    = 3'd1,
		HDR_LOROM   = 3'd2,
		HDR_HIROM   = 3'd3,
		HDR_EXHIROM = 3'd4
	} header_mode_e;

	typedef enum logic [1:0] {
		REG_AUTO = 2'd0,
		REG_NTSC = 2'd1,
		REG_PAL  = 2'd2
	} region_e;

	typedef struct packed {
		logic [7:0]  rom_type;
		logic [23:0] rom_mask;
		logic [23:0] ram_mask;
		logic        pal;
	} cart_info_t;

	// Fields held in big-endian word order
	typedef struct packed {
		logic [31:0] flags;
		logic [31:0] addr;
		logic [31:0] compare;
		logic [31:0] replace;
	} cheat_code_t;

	typedef struct packed {
		logic [16:0] addr;
		logic [7:0]  data;
		logic        we;
	} fill_t;

	// ==============================
	// Save image
	// ==============================

	typedef struct packed {
		logic [31:0] lba;
		logic        rd;
		logic        wr;
	} sd_req_t;

	typedef enum logic {
		BK_IDLE = 1'b0,
		BK_XFER = 1'b1
	} bk_state_e;

endpackage

/* src/rom_header_detect.sv */
module rom_header_detect
	import cart_pkg::*;
(
	input  logic         clk_sys,
	input  logic         RESET,
	input  dl_word_t     dl,
	input  logic         cart_dl,
	input  header_mode_e hdr_mode,
	input  region_e      region,
	output cart_info_t   info
);

	logic [3:0]  rom_size;
	logic [3:0]  ram_size;
	logic        rom_region;
	logic        hdr_write;
	logic        size_fixed;
	logic [24:0] size_base;
	logic [24:0] rom_size_addr;
	logic [24:0] ram_size_addr;

	assign hdr_write = cart_dl & dl.wr;

	// Where the internal header sits for the forced mapping modes
	always_comb begin
		size_fixed = 1'b1;
		case (hdr_mode)
			HDR_LOROM:   size_base = 25'h007FD6;
			HDR_HIROM:   size_base = 25'h00FFD6;
			HDR_EXHIROM: size_base = 25'h40FFD6;
			default: begin
				size_base  = '0;
				size_fixed = 1'b0;
			end
		endcase
	end

	assign rom_size_addr = size_base + 25'(HDR_SKIP);
	assign ram_size_addr = rom_size_addr + 25'd2;

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			rom_size   <= 4'hC;
			ram_size   <= 4'h0;
			rom_region <= 1'b0;
			info       <= '0;
		end else if (hdr_write) begin
			if (dl.addr == '0) begin
				rom_size <= 4'hC;
				ram_size <= 4'h0;
				// Loader puts the sizes in the first byte
				if (hdr_mode == HDR_AUTO && dl.data[7:0] != 8'h00) begin
					{ram_size, rom_size} <= dl.data[7:0];
				end
				case (hdr_mode)
					HDR_NONE, HDR_LOROM: info.rom_type <= 8'd0;
					HDR_HIROM:           info.rom_type <= 8'd1;
					HDR_EXHIROM:         info.rom_type <= 8'd2;
					default:             info.rom_type <= dl.data[15:8];
				endcase
			end

			if (dl.addr == 25'd2) begin
				rom_region <= dl.data[8];
			end

			if (size_fixed) begin
				if (dl.addr == rom_size_addr) rom_size <= dl.data[11:8];
				if (dl.addr == ram_size_addr) ram_size <= dl.data[3:0];
			end

			// Masks use the sizes from before this write
			info.rom_mask <= (24'd1024 << rom_size) - 24'd1;
			info.ram_mask <= (ram_size != 4'h0) ? (24'd1024 << ram_size) - 24'd1 : 24'd0;
		end else if (!cart_dl) begin
			info.pal <= (region == REG_AUTO) ? rom_region : (region == REG_PAL);
		end
	end

endmodule

/* src/cheat_code_loader.sv */
module cheat_code_loader
	import cart_pkg::*;
(
	input  logic        clk_sys,
	input  logic        RESET,
	input  dl_word_t    dl,
	input  logic        code_dl,
	output cheat_code_t code,
	output logic        code_valid
);

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			code_valid <= 1'b0;
		end else begin
			code_valid <= 1'b0;
			if (code_dl && dl.wr) begin
				// Low word first within each field
				case (dl.addr[3:0])
					4'd0:  code.flags[15:0]    <= dl.data;
					4'd2:  code.flags[31:16]   <= dl.data;
					4'd4:  code.addr[15:0]     <= dl.data;
					4'd6:  code.addr[31:16]    <= dl.data;
					4'd8:  code.compare[15:0]  <= dl.data;
					4'd10: code.compare[31:16] <= dl.data;
					4'd12: code.replace[15:0]  <= dl.data;
					4'd14: begin
						code.replace[31:16] <= dl.data;
						// Last word completes the code
						code_valid <= 1'b1;
					end
					default: ;
				endcase
			end
		end
	end

endmodule

/* src/wram_clear.sv */
module wram_clear
	import cart_pkg::*;
#(
	parameter int WRAM_ADDR_W = 17
) (
	input  logic       clk_sys,
	input  logic       RESET,
	input  logic       dl_start,
	input  logic [1:0] wram_pattern,
	output fill_t      fill,
	output logic       clearing
);

	logic [WRAM_ADDR_W-1:0] addr_cnt;

	// ==============================
	// Sweep over the whole RAM
	// ==============================

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			clearing <= 1'b0;
			addr_cnt <= '0;
		end else if (dl_start) begin
			clearing <= 1'b1;
			addr_cnt <= '0;
		end else if (clearing) begin
			if (&addr_cnt) clearing <= 1'b0;
			// Wraps back to zero on the last address
			addr_cnt <= addr_cnt + 1'b1;
		end else begin
			addr_cnt <= '0;
		end
	end

	// Power-on contents as seen on real consoles
	always_comb begin
		fill                        = '0;
		fill.addr[WRAM_ADDR_W-1:0]  = addr_cnt;
		fill.we                     = clearing;
		case (wram_pattern)
			2'd0:    fill.data = (addr_cnt[8] ^ addr_cnt[2]) ? 8'h66 : 8'h99;
			2'd1:    fill.data = (addr_cnt[9] ^ addr_cnt[0]) ? 8'hFF : 8'h00;
			2'd2:    fill.data = 8'h55;
			default: fill.data = 8'hFF;
		endcase
	end

endmodule

/* src/backup_ram_sync.sv */
module backup_ram_sync
	import cart_pkg::*;
(
	input  logic        clk_sys,
	input  logic        RESET,
	input  logic        dl_start,
	input  logic        dl_end,
	input  logic        cart_dl,
	input  logic        img_mounted,
	input  logic        img_readonly,
	input  logic        img_size_nz,
	input  logic        bk_load,
	input  logic        bk_save,
	input  logic        sd_ack,
	input  logic [23:0] ram_mask,
	output sd_req_t     sd_req,
	output logic        bk_busy,
	output logic        bk_loading
);

	bk_state_e   state;
	logic        bk_ena;
	logic        old_load;
	logic        old_save;
	logic        old_ack;
	logic        load_rise;
	logic        save_rise;
	logic [31:0] last_lba;

	assign load_rise = bk_load & bk_ena & ~old_load;
	assign save_rise = bk_save & bk_ena & ~old_save;
	assign last_lba  = 32'(ram_mask >> SECTOR_BITS);
	assign bk_busy   = (state == BK_XFER);

	// Save image gets mounted while the ROM is still coming in
	always_ff @(posedge clk_sys) begin
		if (RESET || dl_start) begin
			bk_ena <= 1'b0;
		end else if (cart_dl && img_mounted && !img_readonly) begin
			bk_ena <= |ram_mask;
		end
	end

	// ==============================
	// Sector sequencer
	// ==============================

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			state      <= BK_IDLE;
			bk_loading <= 1'b0;
			old_load   <= 1'b0;
			old_save   <= 1'b0;
			old_ack    <= 1'b0;
			sd_req     <= '0;
		end else begin
			old_load <= bk_load & bk_ena;
			old_save <= bk_save & bk_ena;
			old_ack  <= sd_ack;

			// Request is taken once ack rises
			if (!old_ack && sd_ack) begin
				sd_req.rd <= 1'b0;
				sd_req.wr <= 1'b0;
			end

			case (state)
				BK_IDLE: begin
					if (load_rise || save_rise) begin
						state      <= BK_XFER;
						bk_loading <= load_rise;
						sd_req.lba <= '0;
						sd_req.rd  <= load_rise;
						sd_req.wr  <= ~load_rise;
					end
					// End of download restores the save
					if (dl_end && img_size_nz && bk_ena) begin
						state      <= BK_XFER;
						bk_loading <= 1'b1;
						sd_req.lba <= '0;
						sd_req.rd  <= 1'b1;
						sd_req.wr  <= 1'b0;
					end
				end
				default: begin
					if (old_ack && !sd_ack) begin
						if (sd_req.lba >= last_lba) begin
							state      <= BK_IDLE;
							bk_loading <= 1'b0;
						end else begin
							sd_req.lba <= sd_req.lba + 32'd1;
							sd_req.rd  <= bk_loading;
							sd_req.wr  <= ~bk_loading;
						end
					end
				end
			endcase
		end
	end

endmodule

/* src/cart_loader.sv */
module cart_loader
	import cart_pkg::*;
#(
	parameter int WRAM_ADDR_W = 17
) (
	input  logic         clk_sys,
	input  logic         RESET,
	input  dl_word_t     dl,
	input  header_mode_e hdr_mode,
	input  region_e      region,
	input  logic [1:0]   wram_pattern,
	input  logic         bk_load,
	input  logic         bk_save,
	input  logic         img_mounted,
	input  logic         img_readonly,
	input  logic         img_size_nz,
	input  logic         sd_ack,
	output cart_info_t   info,
	output cheat_code_t  code,
	output logic         code_valid,
	output fill_t        fill,
	output sd_req_t      sd_req,
	output logic         bk_busy,
	output logic         core_reset
);

	logic cart_dl;
	logic code_dl;
	logic cart_dl_q;
	logic dl_start;
	logic dl_end;
	logic clearing;
	logic bk_loading;

	// ==============================
	// Download decode
	// ==============================

	assign cart_dl = dl.active && (dl.index[5:0] == CART_INDEX[5:0]);
	assign code_dl = dl.active && (dl.index == CHEAT_INDEX);

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			cart_dl_q <= 1'b0;
		end else begin
			cart_dl_q <= cart_dl;
		end
	end

	assign dl_start = cart_dl & ~cart_dl_q;
	assign dl_end   = ~cart_dl & cart_dl_q;

	// Core stays in reset through loading and clearing
	assign core_reset = RESET | cart_dl | bk_loading | clearing;

	rom_header_detect i_rom_header_detect (
		.clk_sys  (clk_sys),
		.RESET    (RESET),
		.dl       (dl),
		.cart_dl  (cart_dl),
		.hdr_mode (hdr_mode),
		.region   (region),
		.info     (info)
	);

	cheat_code_loader i_cheat_code_loader (
		.clk_sys    (clk_sys),
		.RESET      (RESET),
		.dl         (dl),
		.code_dl    (code_dl),
		.code       (code),
		.code_valid (code_valid)
	);

	wram_clear #(
		.WRAM_ADDR_W (WRAM_ADDR_W)
	) i_wram_clear (
		.clk_sys      (clk_sys),
		.RESET        (RESET),
		.dl_start     (dl_start),
		.wram_pattern (wram_pattern),
		.fill         (fill),
		.clearing     (clearing)
	);

	backup_ram_sync i_backup_ram_sync (
		.clk_sys      (clk_sys),
		.RESET        (RESET),
		.dl_start     (dl_start),
		.dl_end       (dl_end),
		.cart_dl      (cart_dl),
		.img_mounted  (img_mounted),
		.img_readonly (img_readonly),
		.img_size_nz  (img_size_nz),
		.bk_load      (bk_load),
		.bk_save      (bk_save),
		.sd_ack       (sd_ack),
		.ram_mask     (info.ram_mask),
		.sd_req       (sd_req),
		.bk_busy      (bk_busy),
		.bk_loading   (bk_loading)
	);

endmodule

/* dv/cart_loader_asserts.sv */
module cart_loader_asserts
	import cart_pkg::*;
(
	input logic    clk_sys,
	input logic    RESET,
	input sd_req_t sd_req,
	input fill_t   fill,
	input logic    dl_start,
	input logic    code_valid
);

	int req_fails  = 0;
	int fill_fails = 0;
	int code_fails = 0;

	// Only one direction pending toward the save image
	a_req_excl: assert property (@(posedge clk_sys) disable iff (RESET)
		!(sd_req.rd && sd_req.wr))
	else begin
		$error("sd_req.rd and sd_req.wr are high together");
		req_fails++;
	end

	// Clearing only begins right after a download start
	a_fill_in_clear: assert property (@(posedge clk_sys) disable iff (RESET)
		$rose(fill.we) |-> $past(dl_start))
	else begin
		$error("fill.we rose without a download start");
		fill_fails++;
	end

	a_code_pulse: assert property (@(posedge clk_sys) disable iff (RESET)
		code_valid |=> !code_valid)
	else begin
		$error("code_valid stayed high for more than one cycle");
		code_fails++;
	end

endmodule

/* dv/cart_checker.sv */
module cart_checker
	import cart_pkg::*;
(
	input logic        clk_sys,
	input logic        RESET,
	input logic        count_clr,
	input logic [1:0]  wram_pattern,
	input cheat_code_t code,
	input logic        code_valid,
	input fill_t       fill,
	input sd_req_t     sd_req,
	input logic        bk_busy,
	input logic        core_reset
);

	int          fill_cnt;
	int          rd_cnt;
	int          wr_cnt;
	int          code_cnt;
	int          watch_errs = 0;
	int          value_errs = 0;
	cheat_code_t code_seen;
	logic        prev_rd;
	logic        prev_wr;
	logic        load_xfer;

	// Power-on byte expected at one work RAM address
	function automatic logic [7:0] pattern_byte(input logic [1:0] pat, input logic [16:0] addr);
		case (pat)
			2'd0:    return (addr[8] != addr[2]) ? 8'h66 : 8'h99;
			2'd1:    return (addr[9] != addr[0]) ? 8'hFF : 8'h00;
			2'd2:    return 8'h55;
			default: return 8'hFF;
		endcase
	endfunction

	task automatic compare(input string name, input logic [127:0] got, input logic [127:0] exp);
		if (got !== exp) begin
			$display("Fail %s got %0h expected %0h", name, got, exp);
			value_errs++;
		end
	endtask

	// ==============================
	// Output monitors
	// ==============================

	always @(posedge clk_sys) begin
		if (RESET || count_clr) begin
			fill_cnt  <= 0;
			rd_cnt    <= 0;
			wr_cnt    <= 0;
			code_cnt  <= 0;
			load_xfer <= 1'b0;
			prev_rd   <= 1'b0;
			prev_wr   <= 1'b0;
		end else begin
			if (fill.we) begin
				if (fill.addr !== 17'(fill_cnt)) begin
					$display("Fail fill.addr got %h expected %h", fill.addr, 17'(fill_cnt));
					watch_errs = watch_errs + 1;
				end
				if (fill.data !== pattern_byte(wram_pattern, 17'(fill_cnt))) begin
					$display("Fail fill.data got %h expected %h", fill.data,
						pattern_byte(wram_pattern, 17'(fill_cnt)));
					watch_errs = watch_errs + 1;
				end
				fill_cnt <= fill_cnt + 1;
			end

			// Each new request must carry the next sector number
			if (sd_req.rd && !prev_rd) begin
				if (sd_req.lba !== 32'(rd_cnt)) begin
					$display("Fail sd_req.lba got %h expected %h", sd_req.lba, 32'(rd_cnt));
					watch_errs = watch_errs + 1;
				end
				rd_cnt <= rd_cnt + 1;
			end
			if (sd_req.wr && !prev_wr) begin
				if (sd_req.lba !== 32'(wr_cnt)) begin
					$display("Fail sd_req.lba got %h expected %h", sd_req.lba, 32'(wr_cnt));
					watch_errs = watch_errs + 1;
				end
				wr_cnt <= wr_cnt + 1;
			end

			if (sd_req.rd && !prev_rd) begin
				load_xfer <= 1'b1;
			end else if (!bk_busy) begin
				load_xfer <= 1'b0;
			end
			if (load_xfer && bk_busy && !core_reset) begin
				$display("Fail core_reset got %h expected %h", core_reset, 1'b1);
				watch_errs = watch_errs + 1;
			end

			if (code_valid) begin
				code_cnt  <= code_cnt + 1;
				code_seen <= code;
			end
			prev_rd <= sd_req.rd;
			prev_wr <= sd_req.wr;
		end
	end

endmodule

/* dv/tb_cart_loader.sv */
module tb_cart_loader
	import cart_pkg::*;
();

	localparam int NUM_ROWS    = 5;
	localparam int ROW_CYCLES  = 2000;
	localparam int CYCLE_LIMIT = 16 + (NUM_ROWS + 1) * ROW_CYCLES;
	localparam int FILL_WORDS  = 1024;

	typedef struct packed {
		header_mode_e hdr_mode;
		region_e      region;
		logic [1:0]   pattern;
		logic         mount;
		logic         ro;
		logic [15:0]  w0;
		logic [15:0]  w2;
		logic [15:0]  wrom;
		logic [15:0]  wram;
		cart_info_t   exp_info;
		logic [15:0]  sectors;
	} row_t;

	logic         clk_sys;
	logic         RESET;
	dl_word_t     dl;
	header_mode_e hdr_mode;
	region_e      region;
	logic [1:0]   wram_pattern;
	logic         bk_load;
	logic         bk_save;
	logic         img_mounted;
	logic         img_readonly;
	logic         img_size_nz;
	logic         sd_ack;
	logic         count_clr;
	cart_info_t   info;
	cheat_code_t  code;
	logic         code_valid;
	fill_t        fill;
	sd_req_t      sd_req;
	logic         bk_busy;
	logic         core_reset;
	row_t         rows [NUM_ROWS];
	logic [31:0]  lfsr;
	logic [31:0]  ack_lfsr;
	int           cycles = 0;
	int           tests_passed = 0;
	int           tests_failed = 0;

	cart_loader #(
		.WRAM_ADDR_W (10)
	) i_cart_loader (
		.clk_sys      (clk_sys),
		.RESET        (RESET),
		.dl           (dl),
		.hdr_mode     (hdr_mode),
		.region       (region),
		.wram_pattern (wram_pattern),
		.bk_load      (bk_load),
		.bk_save      (bk_save),
		.img_mounted  (img_mounted),
		.img_readonly (img_readonly),
		.img_size_nz  (img_size_nz),
		.sd_ack       (sd_ack),
		.info         (info),
		.code         (code),
		.code_valid   (code_valid),
		.fill         (fill),
		.sd_req       (sd_req),
		.bk_busy      (bk_busy),
		.core_reset   (core_reset)
	);

	cart_checker i_cart_checker (
		.clk_sys      (clk_sys),
		.RESET        (RESET),
		.count_clr    (count_clr),
		.wram_pattern (wram_pattern),
		.code         (code),
		.code_valid   (code_valid),
		.fill         (fill),
		.sd_req       (sd_req),
		.bk_busy      (bk_busy),
		.core_reset   (core_reset)
	);

	bind cart_loader cart_loader_asserts i_cart_loader_asserts (
		.clk_sys    (clk_sys),
		.RESET      (RESET),
		.sd_req     (sd_req),
		.fill       (fill),
		.dl_start   (dl_start),
		.code_valid (code_valid)
	);

	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout after %0d cycles, the DUT never finished a test", cycles);
			$display("TEST FAILED");
			$finish;
		end
	end

	// ==============================
	// Helpers
	// ==============================

	// Taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic draw_bits(input int n, inout logic [31:0] s, output logic [15:0] val);
		val = '0;
		for (int b = 0; b < n; b++) begin
			s   = lfsr_step(s);
			val = {val[14:0], s[0]};
		end
	endtask

	function automatic int error_total();
		return i_cart_checker.value_errs + i_cart_checker.watch_errs
			+ i_cart_loader.i_cart_loader_asserts.req_fails
			+ i_cart_loader.i_cart_loader_asserts.fill_fails
			+ i_cart_loader.i_cart_loader_asserts.code_fails;
	endfunction

	task automatic report_test(input string name, input int errs_before);
		if (error_total() == errs_before) begin
			$display("%s passed", name);
			tests_passed++;
		end else begin
			$display("%s failed with %0d errors", name, error_total() - errs_before);
			tests_failed++;
		end
	endtask

	task automatic write_word(input logic [24:0] addr, input logic [15:0] data);
		dl.addr = addr;
		dl.data = data;
		dl.wr   = 1'b1;
		@(negedge clk_sys);
		dl.wr   = 1'b0;
	endtask

	task automatic clear_counts();
		count_clr = 1'b1;
		@(negedge clk_sys);
		count_clr = 1'b0;
	endtask

	task automatic wait_transfer(input logic expected);
		if (expected) begin
			while (!bk_busy) @(negedge clk_sys);
			while (bk_busy) @(negedge clk_sys);
		end else begin
			repeat (8) @(negedge clk_sys);
		end
	endtask

	// Short random latency between request and ack
	initial begin : ack_model
		logic [15:0] delay;
		ack_lfsr = 32'hca6d;
		sd_ack   = 1'b0;
		forever begin
			@(negedge clk_sys);
			if (sd_req.rd || sd_req.wr) begin
				draw_bits(2, ack_lfsr, delay);
				repeat (int'(delay) + 1) @(negedge clk_sys);
				sd_ack = 1'b1;
				repeat (2) @(negedge clk_sys);
				sd_ack = 1'b0;
			end
		end
	end

	// ==============================
	// Tests
	// ==============================

	task automatic run_cart_row(input int r);
		row_t        row;
		logic [24:0] size_addr;
		logic [15:0] filler;
		int          errs_before;
		row         = rows[r];
		errs_before = error_total();
		case (row.hdr_mode)
			HDR_HIROM:   size_addr = 25'h00FFD6 + 25'd512;
			HDR_EXHIROM: size_addr = 25'h40FFD6 + 25'd512;
			default:     size_addr = 25'h007FD6 + 25'd512;
		endcase
		hdr_mode     = row.hdr_mode;
		region       = row.region;
		wram_pattern = row.pattern;
		img_readonly = row.ro;
		img_size_nz  = 1'b1;
		clear_counts();

		// Only the low six index bits select the ROM slot
		dl.active = 1'b1;
		dl.index  = r[0] ? 8'h40 : CART_INDEX;
		write_word(25'd0, row.w0);
		write_word(25'd2, row.w2);
		write_word(size_addr, row.wrom);
		write_word(size_addr + 25'd2, row.wram);
		for (int k = 0; k < 6; k++) begin
			draw_bits(16, lfsr, filler);
			write_word(25'h10 + 25'(2 * k), filler);
		end
		img_mounted = row.mount;
		@(negedge clk_sys);
		img_mounted = 1'b0;
		dl.active   = 1'b0;
		repeat (2) @(negedge clk_sys);

		i_cart_checker.compare("info.rom_type", 128'(info.rom_type), 128'(row.exp_info.rom_type));
		i_cart_checker.compare("info.rom_mask", 128'(info.rom_mask), 128'(row.exp_info.rom_mask));
		i_cart_checker.compare("info.ram_mask", 128'(info.ram_mask), 128'(row.exp_info.ram_mask));
		i_cart_checker.compare("info.pal", 128'(info.pal), 128'(row.exp_info.pal));

		wait_transfer(row.sectors != 0);
		i_cart_checker.compare("sd_req.rd count", 128'(i_cart_checker.rd_cnt), 128'(row.sectors));
		bk_save = 1'b1;
		wait_transfer(row.sectors != 0);
		bk_save = 1'b0;
		i_cart_checker.compare("sd_req.wr count", 128'(i_cart_checker.wr_cnt), 128'(row.sectors));

		while (fill.we) @(negedge clk_sys);
		i_cart_checker.compare("fill.we count", 128'(i_cart_checker.fill_cnt), 128'(FILL_WORDS));

		// Reload once clearing is over, so only the load holds the core in reset
		clear_counts();
		bk_load = 1'b1;
		wait_transfer(row.sectors != 0);
		bk_load = 1'b0;
		i_cart_checker.compare("sd_req.rd reload count", 128'(i_cart_checker.rd_cnt),
			128'(row.sectors));
		report_test($sformatf("cart row %0d", r), errs_before);
	endtask

	task automatic run_cheat();
		logic [15:0] words [8];
		cheat_code_t expected;
		int          errs_before;
		errs_before = error_total();
		clear_counts();
		dl.active = 1'b1;
		dl.index  = CHEAT_INDEX;
		for (int w = 0; w < 8; w++) begin
			draw_bits(16, lfsr, words[w]);
			write_word(25'h100 + 25'(2 * w), words[w]);
		end
		dl.active = 1'b0;
		repeat (4) @(negedge clk_sys);

		// High word of each field arrives second
		expected = {words[1], words[0], words[3], words[2], words[5], words[4], words[7], words[6]};
		i_cart_checker.compare("code_valid count", 128'(i_cart_checker.code_cnt), 128'(1));
		i_cart_checker.compare("code", 128'(i_cart_checker.code_seen), 128'(expected));
		i_cart_checker.compare("fill.we count", 128'(i_cart_checker.fill_cnt), 128'(0));
		report_test("cheat code", errs_before);
	endtask

	initial begin
		lfsr         = 32'hca6d;
		RESET        = 1'b1;
		dl           = '0;
		hdr_mode     = HDR_AUTO;
		region       = REG_AUTO;
		wram_pattern = 2'd0;
		bk_load      = 1'b0;
		bk_save      = 1'b0;
		img_mounted  = 1'b0;
		img_readonly = 1'b0;
		img_size_nz  = 1'b0;
		count_clr    = 1'b0;

		// Mode, region, pattern, mount, ro, words, expected info, sectors
		rows[0] = '{HDR_AUTO, REG_AUTO, 2'd0, 1'b1, 1'b0, 16'h2513, 16'h0100, 16'h0B00, 16'h0005,
			'{8'h25, 24'h001FFF, 24'h0007FF, 1'b1}, 16'd4};
		rows[1] = '{HDR_AUTO, REG_NTSC, 2'd1, 1'b1, 1'b0, 16'h0100, 16'h0100, 16'h0B00, 16'h0005,
			'{8'h01, 24'h3FFFFF, 24'h000000, 1'b0}, 16'd0};
		rows[2] = '{HDR_LOROM, REG_PAL, 2'd2, 1'b1, 1'b0, 16'h7733, 16'h0000, 16'h3A5C, 16'hA5F3,
			'{8'h00, 24'h0FFFFF, 24'h001FFF, 1'b1}, 16'd16};
		rows[3] = '{HDR_HIROM, REG_AUTO, 2'd3, 1'b1, 1'b0, 16'h0000, 16'h0000, 16'hCB11, 16'h7702,
			'{8'h01, 24'h1FFFFF, 24'h000FFF, 1'b0}, 16'd8};
		rows[4] = '{HDR_EXHIROM, REG_NTSC, 2'd0, 1'b1, 1'b1, 16'h1234, 16'h0100, 16'h0D00, 16'hFFF1,
			'{8'h02, 24'h7FFFFF, 24'h0007FF, 1'b0}, 16'd0};

		repeat (16) @(negedge clk_sys);
		RESET = 1'b0;

		for (int r = 0; r < NUM_ROWS; r++) begin
			run_cart_row(r);
		end
		run_cheat();

		$display("Summary: %0d tests passed, %0d tests failed, %0d errors",
			tests_passed, tests_failed, error_total());
		if (tests_failed == 0 && error_total() == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

/* vlog.f */
src/cart_pkg.sv
src/rom_header_detect.sv
src/cheat_code_loader.sv
src/wram_clear.sv
src/backup_ram_sync.sv
src/cart_loader.sv
dv/cart_loader_asserts.sv
dv/cart_checker.sv
dv/tb_cart_loader.sv

/* run.sh */
#!/bin/sh
verilator --binary --timing --assert --top-module tb_cart_loader -f vlog.f || exit 1
out=$(./obj_dir/Vtb_cart_loader +verilator+error+limit+1000)
echo "$out"
echo "$out" | grep -q "TEST OK" && exit 0 || exit 1
